//--- sim.f
+incdir+bench
source/chip_bus_pkg.sv
source/ahbl_if.sv
source/ahbl_splitter.sv
source/ahb_sync_sram.sv
source/ahbl_to_apb.sv
source/bus_fabric.sv
bench/tb_bus_fabric.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the bus fabric testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_bus_fabric \
    --Mdir obj_dir -o sim_tb \
    -f sim.f

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log; then
    exit 1
fi
if ! grep -q "Verification passed" sim.log; then
    exit 1
fi
exit 0

//--- bench/tb_checks.svh
/*
 * Testbench support: transfer and APB record types, SRAM model,
 * lane merge rule and typed compare tasks
 */

typedef struct {
    logic                  valid;
    int                    kind;
    chip_bus_pkg::addr_t   addr;
    logic                  write;
    chip_bus_pkg::hsize_t  size;
    chip_bus_pkg::data_t   wdata;
} xfer_t;

typedef struct {
    chip_bus_pkg::addr_t addr;
    logic                write;
    chip_bus_pkg::data_t wdata;
    chip_bus_pkg::data_t rdata;
    logic                err;
} apb_rec_t;

localparam int KIND_SRAM  = 0;
localparam int KIND_APB   = 1;
localparam int KIND_UNMAP = 2;

// Sparse SRAM model, word index modulo depth
chip_bus_pkg::data_t sram_model [int];
apb_rec_t            apb_log [$];
int                  errors = 0;
int                  checks = 0;

function automatic int word_index(chip_bus_pkg::addr_t a);
    return int'(a >> 2) % IRAM_DEPTH;
endfunction

// Only the lanes covered by size and address change
function automatic chip_bus_pkg::data_t merge_lanes(chip_bus_pkg::data_t old,
        chip_bus_pkg::data_t wd, chip_bus_pkg::addr_t a, chip_bus_pkg::hsize_t s);
    chip_bus_pkg::data_t m;
    case (s)
        chip_bus_pkg::BYTE: m = 32'h0000_00ff << (8 * a[1:0]);
        chip_bus_pkg::HALF: m = 32'h0000_ffff << (16 * a[1]);
        default:            m = '1;
    endcase
    return (old & ~m) | (wd & m);
endfunction

task automatic check_rdata(input chip_bus_pkg::data_t got, input chip_bus_pkg::data_t exp,
        input string what);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("ERR %0t: %s read data %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_resp(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("ERR %0t: %s hresp %b, expected %b", $time, what, got, exp);
    end
endtask

task automatic check_apb(input chip_bus_pkg::addr_t got_a, input chip_bus_pkg::addr_t exp_a,
        input logic got_w, input logic exp_w,
        input chip_bus_pkg::data_t got_d, input chip_bus_pkg::data_t exp_d);
    checks++;
    if (got_a !== exp_a || got_w !== exp_w || (exp_w && got_d !== exp_d)) begin
        errors++;
        $display("ERR %0t: APB transfer %h/%b/%h, expected %h/%b/%h",
            $time, got_a, got_w, got_d, exp_a, exp_w, exp_d);
    end
endtask

//--- bench/tb_bus_fabric.sv
/*
 * Testbench for the bus fabric: clock and reset, pipelined random
 * AHB-Lite master, APB peripheral model, watchdog and summary
 */

`default_nettype none

module tb_bus_fabric;

    localparam int IRAM_DEPTH = 2048;
    localparam int N_PHASE    = 200;
    localparam int N_TOTAL    = 5 * N_PHASE;

    logic                  clk_sys = 1'b0;
    logic                  arst_n  = 1'b0;
    chip_bus_pkg::addr_t   haddr   = '0;
    logic                  hwrite  = 1'b0;
    chip_bus_pkg::htrans_t htrans  = chip_bus_pkg::IDLE;
    chip_bus_pkg::hsize_t  hsize   = chip_bus_pkg::WORD;
    chip_bus_pkg::data_t   hwdata  = '0;
    chip_bus_pkg::data_t   prdata  = '0;
    logic                  pready  = 1'b0;
    logic                  pslverr = 1'b0;
    logic                  hready;
    logic                  hresp;
    chip_bus_pkg::data_t   hrdata;
    chip_bus_pkg::addr_t   paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    chip_bus_pkg::data_t   pwdata;

    `include "tb_checks.svh"

    xfer_t ap;
    xfer_t dp;
    int    wait_cnt;
    int    n_tests = 0;

    bus_fabric #(.IRAM_DEPTH(IRAM_DEPTH)) dut0 (
        .clk_sys(clk_sys), .arst_n(arst_n),
        .haddr(haddr), .hwrite(hwrite), .htrans(htrans), .hsize(hsize), .hwdata(hwdata),
        .hready(hready), .hresp(hresp), .hrdata(hrdata),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    initial begin
        forever #50 clk_sys = ~clk_sys;
    end

    // --------------------
    // APB peripheral with 0 to 3 wait states
    always @(posedge clk_sys) begin
        #10;
        pready  = 1'b0;
        pslverr = 1'b0;
        if (psel && !penable) begin
            wait_cnt = $urandom % 4;
        end else if (psel && penable) begin
            if (wait_cnt == 0) begin
                pready  = 1'b1;
                prdata  = $urandom;
                pslverr = ($urandom % 5) == 0;
                apb_log.push_back('{paddr, pwrite, pwdata, prdata, pslverr});
            end else begin
                wait_cnt--;
            end
        end
    end

    function automatic xfer_t next_xfer(input int mode, input xfer_t prev);
        xfer_t       x;
        int unsigned r;
        r        = $urandom;
        x.valid  = 1'b1;
        x.kind   = KIND_SRAM;
        x.write  = 1'($urandom % 2);
        x.size   = chip_bus_pkg::WORD;
        x.wdata  = $urandom;
        // Small index range so words get reused, mirror bits above the depth
        x.addr   = chip_bus_pkg::addr_t'(20'h80000 | ((r % 32) << 13) |
                                         (((r >> 8) % 32) << 2));
        if (mode == 4) begin
            r = $urandom % 3;
            mode = (r == 0) ? 5 : ((r == 1) ? 3 : 1);
        end
        if (mode == 3) begin
            x.kind = KIND_APB;
            x.addr = 20'he0000 | (chip_bus_pkg::addr_t'($urandom) & 20'h1fffc);
        end else if (mode == 5) begin
            x.kind = KIND_UNMAP;
            r      = $urandom;
            // Keeps the SRAM word index, so a stray write would land on a used word
            x.addr = (x.addr & 20'h1fffc) | (r[0] ? {1'b0, r[2:1], 17'h0} : 20'hc0000);
        end else if (mode == 2 && prev.valid && prev.kind == KIND_SRAM && prev.write) begin
            x.addr  = {prev.addr[19:2], 2'b00};
            x.write = 1'b0;
        end else if (mode != 0 && sram_model.exists(word_index(x.addr)) && x.write) begin
            r = $urandom % 3;
            if (r == 0) begin
                x.size = chip_bus_pkg::BYTE;
                x.addr[1:0] = 2'($urandom);
            end else if (r == 1) begin
                x.size = chip_bus_pkg::HALF;
                x.addr[1:0] = {1'($urandom), 1'b0};
            end
        end
        if (x.kind == KIND_SRAM && !x.write && !sram_model.exists(word_index(x.addr)) &&
                !(mode == 2 && prev.valid && prev.write)) begin
            x.write = 1'b1;
        end
        return x;
    endfunction

    task automatic drive_bus();
        htrans = ap.valid ? chip_bus_pkg::NONSEQ : chip_bus_pkg::IDLE;
        haddr  = ap.addr;
        hwrite = ap.write;
        hsize  = ap.size;
        hwdata = (dp.valid && dp.write) ? dp.wdata : '0;
    endtask

    task automatic finish_xfer(input xfer_t x, input logic resp, input chip_bus_pkg::data_t rd,
            input logic prev_err);
        apb_rec_t rec;
        int       idx;
        idx = word_index(x.addr);
        if (x.kind == KIND_SRAM) begin
            check_resp(resp, 1'b0, "SRAM");
            if (x.write) begin
                sram_model[idx] = merge_lanes(sram_model.exists(idx) ? sram_model[idx] : '0,
                    x.wdata, x.addr, x.size);
            end else begin
                check_rdata(rd, sram_model[idx], "SRAM");
            end
        end else if (x.kind == KIND_APB) begin
            if (apb_log.size() == 0) begin
                errors++;
                $display("AHB transfer to %h ended before any APB transfer", x.addr);
            end else begin
                rec = apb_log.pop_front();
                check_apb(rec.addr, x.addr, rec.write, x.write, rec.wdata, x.wdata);
                check_resp(resp, rec.err, "APB");
                if (!x.write && !rec.err) begin
                    check_rdata(rd, rec.rdata, "APB");
                end
            end
        end else begin
            check_resp(resp, 1'b1, "unmapped");
        end
        if (resp && !prev_err) begin
            errors++;
            $display("ERROR response at %0t had no first cycle with hready low", $time);
        end
    endtask

    task automatic run_phase(input int mode, input string name);
        int   issued;
        int   err_before;
        logic err_pend;
        err_before = errors;
        err_pend   = 1'b0;
        dp.valid   = 1'b0;
        ap         = next_xfer(mode, dp);
        issued     = 1;
        drive_bus();
        while (ap.valid || dp.valid) begin
            @(negedge clk_sys);
            if (hready) begin
                if (dp.valid) begin
                    finish_xfer(dp, hresp, hrdata, err_pend);
                end
                dp = ap;
                if (issued < N_PHASE) begin
                    ap = next_xfer(mode, dp);
                    issued++;
                end else begin
                    ap.valid = 1'b0;
                end
            end
            err_pend = !hready && hresp;
            @(posedge clk_sys);
            #10;
            drive_bus();
        end
        n_tests++;
        $display("%-12s %0d transfers, %0d errors", name, issued, errors - err_before);
    endtask

    // --------------------
    // Watchdog sized from the transfer count
    initial begin
        #(N_TOTAL * 10 * 100 + 1000);
        $display("Run stopped by the watchdog before the tests finished");
        $display("Verification failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h768a));
        ap.valid = 1'b0;
        dp.valid = 1'b0;
        repeat (2) @(posedge clk_sys);
        #10;
        arst_n = 1'b1;
        @(negedge clk_sys);
        check_resp(hresp, 1'b0, "reset");
        if (!hready || psel || penable) begin
            errors++;
            $display("ERR %0t: after reset hready %b, psel %b, penable %b",
                $time, hready, psel, penable);
        end
        n_tests++;
        $display("%-12s %0d errors", "reset", errors);
        @(posedge clk_sys);
        #10;
        run_phase(0, "sram_words");
        run_phase(1, "byte_lanes");
        run_phase(2, "forwarding");
        run_phase(3, "apb_path");
        run_phase(4, "errors");
        if (apb_log.size() != 0) begin
            errors++;
            $display("%0d APB transfers had no matching AHB transfer", apb_log.size());
        end
        $display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/bus_fabric.sv
/*
 * System bus fabric top level: single AHB-Lite master port,
 * splitter, internal SRAM and APB bridge
 */

`default_nettype none

module bus_fabric #(
    parameter int IRAM_DEPTH = chip_bus_pkg::IRAM_DEPTH
) (
    input  wire                        clk_sys,
    input  wire                        arst_n,

    // AHB-Lite master port
    input  wire chip_bus_pkg::addr_t   haddr,
    input  wire                        hwrite,
    input  wire chip_bus_pkg::htrans_t htrans,
    input  wire chip_bus_pkg::hsize_t  hsize,
    input  wire chip_bus_pkg::data_t   hwdata,
    output logic                       hready,
    output logic                       hresp,
    output chip_bus_pkg::data_t        hrdata,

    // APB peripheral port
    output chip_bus_pkg::addr_t        paddr,
    output logic                       psel,
    output logic                       penable,
    output logic                       pwrite,
    output chip_bus_pkg::data_t        pwdata,
    input  wire chip_bus_pkg::data_t   prdata,
    input  wire                        pready,
    input  wire                        pslverr
);

    ahbl_if cpu_bus ();
    ahbl_if sram_bus ();
    ahbl_if apb_bus ();

    // --------------------
    // Master side

    assign cpu_bus.haddr  = haddr;
    assign cpu_bus.hwrite = hwrite;
    assign cpu_bus.htrans = htrans;
    assign cpu_bus.hsize  = hsize;
    assign cpu_bus.hwdata = hwdata;

    // Only one master, so the bus hready is the slave response
    assign cpu_bus.hready = cpu_bus.hready_resp;

    assign hready = cpu_bus.hready_resp;
    assign hresp  = cpu_bus.hresp;
    assign hrdata = cpu_bus.hrdata;

    // --------------------
    // Fabric

    ahbl_splitter splitter_u (
        .clk_sys  (clk_sys),
        .arst_n   (arst_n),
        .src      (cpu_bus),
        .sram_bus (sram_bus),
        .apb_bus  (apb_bus)
    );

    ahb_sync_sram #(
        .DEPTH (IRAM_DEPTH)
    ) iram_u (
        .clk_sys (clk_sys),
        .arst_n  (arst_n),
        .bus     (sram_bus)
    );

    ahbl_to_apb apb_bridge_u (
        .clk_sys (clk_sys),
        .arst_n  (arst_n),
        .ahb     (apb_bus),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

endmodule

`default_nettype wire

//--- source/ahbl_to_apb.sv
/*
 * AHB-Lite to APB bridge: one setup cycle then access cycles
 * until pready, with pslverr returned as an AHB ERROR
 */

`default_nettype none

module ahbl_to_apb (
    input  wire                 clk_sys,
    input  wire                 arst_n,
    ahbl_if.slave               ahb,

    output chip_bus_pkg::addr_t paddr,
    output logic                psel,
    output logic                penable,
    output logic                pwrite,
    output chip_bus_pkg::data_t pwdata,
    input  wire chip_bus_pkg::data_t prdata,
    input  wire                 pready,
    input  wire                 pslverr
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_ACCESS,
        ST_ERROR
    } state_t;

    state_t              state;
    logic                hresp_q;
    logic                addr_valid;
    chip_bus_pkg::addr_t paddr_q;
    logic                pwrite_q;
    chip_bus_pkg::data_t wdata_q;
    chip_bus_pkg::data_t rdata_q;

    assign addr_valid = ahb.hready &&
        (ahb.htrans == chip_bus_pkg::NONSEQ || ahb.htrans == chip_bus_pkg::SEQ);

    // --------------------
    // Transfer FSM

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ST_IDLE;
            hresp_q <= 1'b0;
        end else begin
            hresp_q <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (addr_valid) begin
                        state <= ST_SETUP;
                    end
                end
                ST_SETUP: begin
                    state <= ST_ACCESS;
                end
                ST_ACCESS: begin
                    if (pready && pslverr) begin
                        state   <= ST_ERROR;
                        hresp_q <= 1'b1;
                    end else if (pready) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    // Second ERROR cycle is spent back in idle
                    state   <= ST_IDLE;
                    hresp_q <= 1'b1;
                end
            endcase
        end
    end

    // --------------------
    // Payload capture

    always_ff @(posedge clk_sys) begin
        if (state == ST_IDLE && addr_valid) begin
            paddr_q  <= ahb.haddr;
            pwrite_q <= ahb.hwrite;
        end
        if (state == ST_SETUP && pwrite_q) begin
            wdata_q <= ahb.hwdata;
        end
        if (state == ST_ACCESS && pready && !pwrite_q) begin
            rdata_q <= prdata;
        end
    end

    // Write data is live from the AHB data phase during setup
    assign pwdata  = (state == ST_SETUP && pwrite_q) ? ahb.hwdata : wdata_q;
    assign paddr   = paddr_q;
    assign pwrite  = pwrite_q;
    assign psel    = (state == ST_SETUP) || (state == ST_ACCESS);
    assign penable = (state == ST_ACCESS);

    assign ahb.hready_resp = (state == ST_IDLE);
    assign ahb.hresp       = hresp_q;
    assign ahb.hrdata      = rdata_q;

    // Relies on the AHB master holding hwdata while stalled
    apb_stable: assert property (@(posedge clk_sys) disable iff (!arst_n)
        psel && !pready |=> $stable(paddr) && $stable(pwrite) && $stable(pwdata));

endmodule

`default_nettype wire

//--- source/ahb_sync_sram.sv
/*
 * Zero wait state AHB-Lite SRAM with byte lane writes
 * and forwarding of a pending write into a following read
 */

`default_nettype none

module ahb_sync_sram #(
    parameter int DEPTH = 2048
) (
    input  wire   clk_sys,
    input  wire   arst_n,
    ahbl_if.slave bus
);

    localparam int AW      = $clog2(DEPTH);
    localparam int N_LANES = chip_bus_pkg::DATA_W / 8;

    chip_bus_pkg::data_t mem [DEPTH];

    logic               addr_valid;
    logic [AW-1:0]      idx_a;
    logic [N_LANES-1:0] be_a;
    logic               rd_en;
    logic               fwd;

    logic               wr_pend;
    logic [AW-1:0]      wr_idx;
    logic [N_LANES-1:0] wr_be;
    chip_bus_pkg::data_t rd_word;

    assign addr_valid = bus.hready &&
        (bus.htrans == chip_bus_pkg::NONSEQ || bus.htrans == chip_bus_pkg::SEQ);

    // Upper address bits are dropped, which mirrors the array
    assign idx_a = bus.haddr[AW+1:2];
    assign rd_en = addr_valid && !bus.hwrite;
    assign fwd   = wr_pend && (wr_idx == idx_a);

    always_comb begin
        case (bus.hsize)
            chip_bus_pkg::BYTE: be_a = N_LANES'(1) << bus.haddr[1:0];
            chip_bus_pkg::HALF: be_a = N_LANES'(2'b11) << {bus.haddr[1], 1'b0};
            default:            be_a = '1;
        endcase
    end

    // --------------------
    // Write tracking

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            wr_pend <= 1'b0;
        end else if (bus.hready) begin
            wr_pend <= addr_valid && bus.hwrite;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (addr_valid) begin
            wr_idx <= idx_a;
            wr_be  <= be_a;
        end
    end

    // --------------------
    // Array access

    always_ff @(posedge clk_sys) begin
        if (wr_pend && bus.hready) begin
            for (int i = 0; i < N_LANES; i++) begin
                if (wr_be[i]) begin
                    mem[wr_idx][8*i +: 8] <= bus.hwdata[8*i +: 8];
                end
            end
        end
        // Read lands on the edge the write retires, so merge its lanes here
        if (rd_en) begin
            for (int i = 0; i < N_LANES; i++) begin
                if (fwd && wr_be[i]) begin
                    rd_word[8*i +: 8] <= bus.hwdata[8*i +: 8];
                end else begin
                    rd_word[8*i +: 8] <= mem[idx_a][8*i +: 8];
                end
            end
        end
    end

    assign bus.hready_resp = 1'b1;
    assign bus.hresp       = 1'b0;
    assign bus.hrdata      = rd_word;

    aligned_access: assert property (@(posedge clk_sys) disable iff (!arst_n)
        addr_valid |->
            (bus.hsize inside {chip_bus_pkg::BYTE, chip_bus_pkg::HALF, chip_bus_pkg::WORD}) &&
            !(bus.hsize == chip_bus_pkg::HALF && bus.haddr[0]) &&
            !(bus.hsize == chip_bus_pkg::WORD && |bus.haddr[1:0]));

endmodule

`default_nettype wire

//--- source/ahbl_splitter.sv
/*
 * AHB-Lite splitter: address decode against the system map,
 * per-port address phase forwarding, data phase response mux
 * and the default ERROR responder for unmapped addresses
 */

`default_nettype none

module ahbl_splitter (
    input  wire    clk_sys,
    input  wire    arst_n,
    ahbl_if.slave  src,
    ahbl_if.master sram_bus,
    ahbl_if.master apb_bus
);

    logic                    addr_valid;
    chip_bus_pkg::port_sel_t sel_a;
    chip_bus_pkg::port_sel_t sel_d;
    logic                    err_first;
    logic                    err_second;

    // --------------------
    // Address phase decode

    assign addr_valid = src.hready &&
        (src.htrans == chip_bus_pkg::NONSEQ || src.htrans == chip_bus_pkg::SEQ);

    always_comb begin
        sel_a = '0;
        sel_a[chip_bus_pkg::PORT_IRAM] =
            (src.haddr & chip_bus_pkg::IRAM_MASK) == chip_bus_pkg::IRAM_BASE;
        sel_a[chip_bus_pkg::PORT_APB] =
            (src.haddr & chip_bus_pkg::APB_MASK) == chip_bus_pkg::APB_BASE;
    end

    // Unselected ports see an IDLE transfer
    always_comb begin
        sram_bus.haddr  = src.haddr;
        sram_bus.hwrite = src.hwrite;
        sram_bus.hsize  = src.hsize;
        sram_bus.hwdata = src.hwdata;
        sram_bus.hready = src.hready;
        if (sel_a[chip_bus_pkg::PORT_IRAM]) begin
            sram_bus.htrans = src.htrans;
        end else begin
            sram_bus.htrans = chip_bus_pkg::IDLE;
        end

        apb_bus.haddr  = src.haddr;
        apb_bus.hwrite = src.hwrite;
        apb_bus.hsize  = src.hsize;
        apb_bus.hwdata = src.hwdata;
        apb_bus.hready = src.hready;
        if (sel_a[chip_bus_pkg::PORT_APB]) begin
            apb_bus.htrans = src.htrans;
        end else begin
            apb_bus.htrans = chip_bus_pkg::IDLE;
        end
    end

    // --------------------
    // Data phase state

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            sel_d      <= '0;
            err_first  <= 1'b0;
            err_second <= 1'b0;
        end else begin
            // Selection only moves when the bus advances
            if (src.hready) begin
                sel_d <= addr_valid ? sel_a : '0;
            end
            err_first  <= addr_valid && (sel_a == '0);
            err_second <= err_first;
        end
    end

    // --------------------
    // Response mux

    always_comb begin
        src.hready_resp = 1'b1;
        src.hresp       = 1'b0;
        src.hrdata      = '0;
        if (err_first) begin
            src.hready_resp = 1'b0;
            src.hresp       = 1'b1;
        end else if (err_second) begin
            src.hresp = 1'b1;
        end else if (sel_d[chip_bus_pkg::PORT_IRAM]) begin
            src.hready_resp = sram_bus.hready_resp;
            src.hresp       = sram_bus.hresp;
            src.hrdata      = sram_bus.hrdata;
        end else if (sel_d[chip_bus_pkg::PORT_APB]) begin
            src.hready_resp = apb_bus.hready_resp;
            src.hresp       = apb_bus.hresp;
            src.hrdata      = apb_bus.hrdata;
        end
    end

    // --------------------
    // Checks

    sel_onehot: assert property (@(posedge clk_sys) disable iff (!arst_n)
        $onehot0(sel_d));

    // Holds for every slave behind the splitter, not just the local responder
    err_order: assert property (@(posedge clk_sys) disable iff (!arst_n)
        src.hready_resp && src.hresp |-> $past(!src.hready_resp && src.hresp));

endmodule

`default_nettype wire

//--- source/ahbl_if.sv
/*
 * AHB-Lite bus bundle with master and slave modports
 */

`default_nettype none

interface ahbl_if;

    // Address phase
    chip_bus_pkg::addr_t   haddr;
    logic                  hwrite;
    chip_bus_pkg::htrans_t htrans;
    chip_bus_pkg::hsize_t  hsize;

    // Data phase
    chip_bus_pkg::data_t   hwdata;
    logic                  hready;
    logic                  hready_resp;
    logic                  hresp;
    chip_bus_pkg::data_t   hrdata;

    modport master (
        output haddr, hwrite, htrans, hsize, hwdata, hready,
        input  hready_resp, hresp, hrdata
    );

    modport slave (
        input  haddr, hwrite, htrans, hsize, hwdata, hready,
        output hready_resp, hresp, hrdata
    );

endinterface

`default_nettype wire

//--- source/chip_bus_pkg.sv
/*
 * System bus definitions shared by the fabric:
 * bus widths, AHB-Lite transfer types and sizes,
 * slave port indices and the decoded address map
 */

`default_nettype none

package chip_bus_pkg;

    // --------------------
    // Bus widths

    localparam int HADDR_W = 20;
    localparam int DATA_W  = 32;

    typedef logic [HADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0]  data_t;

    // --------------------
    // AHB-Lite encodings

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    typedef enum logic [2:0] {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hsize_t;

    // --------------------
    // Address map, 1 MB space

    localparam int N_PORTS   = 2;
    localparam int PORT_IRAM = 0;
    localparam int PORT_APB  = 1;

    typedef logic [N_PORTS-1:0] port_sel_t;

    // Internal SRAM, mirrored over 80000 to bffff
    localparam addr_t IRAM_BASE = 20'h80000;
    localparam addr_t IRAM_MASK = 20'hc0000;

    // Peripheral window e0000 to fffff
    localparam addr_t APB_BASE  = 20'he0000;
    localparam addr_t APB_MASK  = 20'he0000;

    localparam int IRAM_DEPTH = 2048;

endpackage

`default_nettype wire
